// ==== hw/anabellek_denetleyici.sv ====
// Data path wins ties; requesters hold valid and fields until ready; timer wraps at 2^64
`timescale 1ns/10ps

module anabellek_denetleyici (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,

    // Instruction cache refill
    input  logic                                    l1b_iomem_valid_i,
    input  logic [bellek_paket::KELIME_ADR_GEN+1:2] l1b_iomem_addr_i,
    output logic                                    l1b_iomem_ready_o,
    output logic [bellek_paket::KELIME_GEN-1:0]     l1b_iomem_rdata_o,

    // Data path
    input  logic                                    l1v_iomem_valid_i,
    input  logic [bellek_paket::KELIME_ADR_GEN+1:2] l1v_iomem_addr_i,
    input  logic [3:0]                              l1v_iomem_wstrb_i,
    input  logic [bellek_paket::KELIME_GEN-1:0]     l1v_iomem_wdata_i,
    output logic                                    l1v_iomem_ready_o,
    output logic [bellek_paket::KELIME_GEN-1:0]     l1v_iomem_rdata_o,

    // Cycle timer read
    input  logic                                    zmn_sec_i,
    input  logic                                    zmn_ust_i,
    output logic [bellek_paket::KELIME_GEN-1:0]     zmn_veri_o,

    // External memory
    output logic                                    iomem_valid_o,
    input  logic                                    iomem_ready_i,
    output logic [3:0]                              iomem_wstrb_o,
    output logic [31:0]                             iomem_addr_o,
    output logic [bellek_paket::KELIME_GEN-1:0]     iomem_wdata_o,
    input  logic [bellek_paket::KELIME_GEN-1:0]     iomem_rdata_i
);

    logic                                    izin_l1v_r;
    logic                                    izin_l1b_r;
    logic                                    hat_bos;
    logic [bellek_paket::KELIME_ADR_GEN+1:2] secili_adr;
    logic [2*bellek_paket::KELIME_GEN-1:0]   sayac_r;

    // ########################################
    // Grant
    // ########################################

    assign hat_bos = !izin_l1v_r && !izin_l1b_r;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            izin_l1v_r <= 1'b0;
            izin_l1b_r <= 1'b0;
        end else if (hat_bos) begin
            izin_l1v_r <= l1v_iomem_valid_i;
            izin_l1b_r <= l1b_iomem_valid_i && !l1v_iomem_valid_i;
        end else if (iomem_ready_i) begin
            izin_l1v_r <= 1'b0;
            izin_l1b_r <= 1'b0;
        end
    end

    // ########################################
    // External port mux
    // ########################################

    assign iomem_valid_o = (izin_l1v_r && l1v_iomem_valid_i) ||
                           (izin_l1b_r && l1b_iomem_valid_i);

    assign secili_adr    = izin_l1v_r ? l1v_iomem_addr_i : l1b_iomem_addr_i;

    // Byte address, upper bits zero
    assign iomem_addr_o  = 32'({secili_adr, 2'b00});

    // Instruction side only reads
    assign iomem_wstrb_o = izin_l1v_r ? l1v_iomem_wstrb_i : 4'b0000;
    assign iomem_wdata_o = l1v_iomem_wdata_i;

    // Ready back to the granted side only
    assign l1v_iomem_ready_o = izin_l1v_r && iomem_ready_i;
    assign l1b_iomem_ready_o = izin_l1b_r && iomem_ready_i;
    assign l1v_iomem_rdata_o = iomem_rdata_i;
    assign l1b_iomem_rdata_o = iomem_rdata_i;

    // ########################################
    // Cycle timer
    // ########################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sayac_r <= '0;
        end else begin
            sayac_r <= sayac_r + 1'b1;
        end
    end

    // Returned in the same cycle as the read
    assign zmn_veri_o = !zmn_sec_i ? '0 :
                        zmn_ust_i  ? sayac_r[2*bellek_paket::KELIME_GEN-1:bellek_paket::KELIME_GEN] :
                                     sayac_r[bellek_paket::KELIME_GEN-1:0];

    // ########################################
    // Checks
    // ########################################

    a_tek_hazir: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(l1v_iomem_ready_o && l1b_iomem_ready_o)
    );

    // Granted requester keeps its request steady until ready
    a_dis_adr_sabit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        iomem_valid_o && !iomem_ready_i |=>
            iomem_valid_o && $stable(iomem_addr_o) && $stable(iomem_wstrb_o)
    );

endmodule

// ==== hw/bellek_alt_sistemi.sv ====
// Memory side only; iomem_addr_o is a byte address with bits 31:19 and 1:0 always zero
`timescale 1ns/10ps

module bellek_alt_sistemi (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,

    // Instruction fetch port
    input  logic                                    l1b_istek_i,
    input  logic [bellek_paket::KELIME_ADR_GEN+1:2] l1b_adres_i,
    output logic [bellek_paket::KELIME_GEN-1:0]     l1b_deger_o,
    output logic                                    l1b_bekle_o,

    // Data port
    input  logic                                    bib_sec_i,
    input  logic [31:0]                             bib_adr_i,
    input  logic [bellek_paket::KELIME_GEN-1:0]     bib_veri_i,
    input  logic [3:0]                              bib_maske_i,
    output logic [bellek_paket::KELIME_GEN-1:0]     bib_veri_o,
    output logic                                    bib_durdur_o,

    // External memory
    output logic                                    iomem_valid_o,
    input  logic                                    iomem_ready_i,
    output logic [3:0]                              iomem_wstrb_o,
    output logic [31:0]                             iomem_addr_o,
    output logic [bellek_paket::KELIME_GEN-1:0]     iomem_wdata_o,
    input  logic [bellek_paket::KELIME_GEN-1:0]     iomem_rdata_i
);

    logic                                    l1b_iomem_valid;
    logic [bellek_paket::KELIME_ADR_GEN+1:2] l1b_iomem_addr;
    logic                                    l1b_iomem_ready;
    logic [bellek_paket::KELIME_GEN-1:0]     l1b_iomem_rdata;

    logic                                    l1v_iomem_valid;
    logic [bellek_paket::KELIME_ADR_GEN+1:2] l1v_iomem_addr;
    logic [3:0]                              l1v_iomem_wstrb;
    logic [bellek_paket::KELIME_GEN-1:0]     l1v_iomem_wdata;
    logic                                    l1v_iomem_ready;
    logic [bellek_paket::KELIME_GEN-1:0]     l1v_iomem_rdata;

    logic                                    zmn_sec;
    logic                                    zmn_ust;
    logic [bellek_paket::KELIME_GEN-1:0]     zmn_veri;

    buyruk_onbellegi i_buyruk_onbellegi (
        .clk_i         (clk_i          ),
        .rst_n_i       (rst_n_i        ),
        .l1b_istek_i   (l1b_istek_i    ),
        .l1b_adres_i   (l1b_adres_i    ),
        .l1b_deger_o   (l1b_deger_o    ),
        .l1b_bekle_o   (l1b_bekle_o    ),
        .iomem_valid_o (l1b_iomem_valid),
        .iomem_addr_o  (l1b_iomem_addr ),
        .iomem_ready_i (l1b_iomem_ready),
        .iomem_rdata_i (l1b_iomem_rdata)
    );

    veri_yolu_denetleyici i_veri_yolu_denetleyici (
        .clk_i         (clk_i          ),
        .rst_n_i       (rst_n_i        ),
        .bib_sec_i     (bib_sec_i      ),
        .bib_adr_i     (bib_adr_i      ),
        .bib_veri_i    (bib_veri_i     ),
        .bib_maske_i   (bib_maske_i    ),
        .bib_veri_o    (bib_veri_o     ),
        .bib_durdur_o  (bib_durdur_o   ),
        .iomem_valid_o (l1v_iomem_valid),
        .iomem_addr_o  (l1v_iomem_addr ),
        .iomem_wstrb_o (l1v_iomem_wstrb),
        .iomem_wdata_o (l1v_iomem_wdata),
        .iomem_ready_i (l1v_iomem_ready),
        .iomem_rdata_i (l1v_iomem_rdata),
        .zmn_sec_o     (zmn_sec        ),
        .zmn_ust_o     (zmn_ust        ),
        .zmn_veri_i    (zmn_veri       )
    );

    anabellek_denetleyici i_anabellek_denetleyici (
        .clk_i             (clk_i          ),
        .rst_n_i           (rst_n_i        ),
        .l1b_iomem_valid_i (l1b_iomem_valid),
        .l1b_iomem_addr_i  (l1b_iomem_addr ),
        .l1b_iomem_ready_o (l1b_iomem_ready),
        .l1b_iomem_rdata_o (l1b_iomem_rdata),
        .l1v_iomem_valid_i (l1v_iomem_valid),
        .l1v_iomem_addr_i  (l1v_iomem_addr ),
        .l1v_iomem_wstrb_i (l1v_iomem_wstrb),
        .l1v_iomem_wdata_i (l1v_iomem_wdata),
        .l1v_iomem_ready_o (l1v_iomem_ready),
        .l1v_iomem_rdata_o (l1v_iomem_rdata),
        .zmn_sec_i         (zmn_sec        ),
        .zmn_ust_i         (zmn_ust        ),
        .zmn_veri_o        (zmn_veri       ),
        .iomem_valid_o     (iomem_valid_o  ),
        .iomem_ready_i     (iomem_ready_i  ),
        .iomem_wstrb_o     (iomem_wstrb_o  ),
        .iomem_addr_o      (iomem_addr_o   ),
        .iomem_wdata_o     (iomem_wdata_o  ),
        .iomem_rdata_i     (iomem_rdata_i  )
    );

endmodule

// ==== hw/bellek_paket.sv ====
// Word addresses cover byte address bits 18:2 only; SATIR_SAYISI must be a power of two
package bellek_paket;

    // ########################################
    // Data and address widths
    // ########################################

    // Data bus width
    localparam int KELIME_GEN = 32;

    // Word address, byte address bits 18 down to 2
    localparam int KELIME_ADR_GEN = 17;

    // ########################################
    // Instruction cache geometry
    // ########################################

    // Direct mapped, one word per line
    localparam int SATIR_SAYISI = 8;

    localparam int SATIR_IDX_GEN = $clog2(SATIR_SAYISI);

    // Remaining word address bits above the line index
    localparam int ETIKET_GEN = KELIME_ADR_GEN - SATIR_IDX_GEN;

    // ########################################
    // Address decode
    // ########################################

    // Data address bit that selects the cycle timer
    localparam int ZMN_BIT = 28;

endpackage

// ==== hw/buyruk_onbellegi.sv ====
// Requester must hold l1b_istek_i and l1b_adres_i while l1b_bekle_o is high; lines are flops
`timescale 1ns/10ps

module buyruk_onbellegi (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,

    // Fetch port
    input  logic                                    l1b_istek_i,
    input  logic [bellek_paket::KELIME_ADR_GEN+1:2] l1b_adres_i,
    output logic [bellek_paket::KELIME_GEN-1:0]     l1b_deger_o,
    output logic                                    l1b_bekle_o,

    // Refill request to the arbiter
    output logic                                    iomem_valid_o,
    output logic [bellek_paket::KELIME_ADR_GEN+1:2] iomem_addr_o,
    input  logic                                    iomem_ready_i,
    input  logic [bellek_paket::KELIME_GEN-1:0]     iomem_rdata_i
);

    logic [bellek_paket::SATIR_SAYISI-1:0]  gecerli_r;
    logic [bellek_paket::ETIKET_GEN-1:0]    etiket_r [bellek_paket::SATIR_SAYISI];
    logic [bellek_paket::KELIME_GEN-1:0]    veri_r   [bellek_paket::SATIR_SAYISI];

    logic [bellek_paket::SATIR_IDX_GEN-1:0] satir_idx;
    logic [bellek_paket::ETIKET_GEN-1:0]    istek_etiket;
    logic                                   isabet;
    logic                                   dolum_bitti;

    // ########################################
    // Lookup
    // ########################################

    assign satir_idx    = l1b_adres_i[bellek_paket::SATIR_IDX_GEN+1:2];
    assign istek_etiket =
        l1b_adres_i[bellek_paket::KELIME_ADR_GEN+1:bellek_paket::SATIR_IDX_GEN+2];

    // Hit straight from the registered line
    assign isabet = gecerli_r[satir_idx] && (etiket_r[satir_idx] == istek_etiket);

    assign l1b_deger_o = veri_r[satir_idx];
    assign l1b_bekle_o = l1b_istek_i && !isabet;

    // ########################################
    // Refill
    // ########################################

    // Missed word is fetched with the held fetch address
    assign iomem_valid_o = l1b_bekle_o;
    assign iomem_addr_o  = l1b_adres_i;
    assign dolum_bitti   = iomem_valid_o && iomem_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gecerli_r <= '0;
        end else if (dolum_bitti) begin
            gecerli_r[satir_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dolum_bitti) begin
            etiket_r[satir_idx] <= istek_etiket;
            veri_r[satir_idx]   <= iomem_rdata_i;
        end
    end

    // ########################################
    // Checks
    // ########################################

    // Fetch address held by the core for the whole refill
    a_dolum_adr_sabit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        iomem_valid_o && !iomem_ready_i |=> iomem_valid_o && $stable(iomem_addr_o)
    );

    // Held fetch hits right after its refill
    a_dolum_sonra_isabet: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        dolum_bitti |=> !l1b_bekle_o
    );

endmodule

// ==== hw/veri_yolu_denetleyici.sv ====
// Core holds bib_* while bib_durdur_o is high; timer is read only, writes to it are dropped
`timescale 1ns/10ps

module veri_yolu_denetleyici (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,

    // Core data port
    input  logic                                    bib_sec_i,
    input  logic [31:0]                             bib_adr_i,
    input  logic [bellek_paket::KELIME_GEN-1:0]     bib_veri_i,
    input  logic [3:0]                              bib_maske_i,
    output logic [bellek_paket::KELIME_GEN-1:0]     bib_veri_o,
    output logic                                    bib_durdur_o,

    // Request to the arbiter
    output logic                                    iomem_valid_o,
    output logic [bellek_paket::KELIME_ADR_GEN+1:2] iomem_addr_o,
    output logic [3:0]                              iomem_wstrb_o,
    output logic [bellek_paket::KELIME_GEN-1:0]     iomem_wdata_o,
    input  logic                                    iomem_ready_i,
    input  logic [bellek_paket::KELIME_GEN-1:0]     iomem_rdata_i,

    // Cycle timer
    output logic                                    zmn_sec_o,
    output logic                                    zmn_ust_o,
    input  logic [bellek_paket::KELIME_GEN-1:0]     zmn_veri_i
);

    logic                                    tampon_dolu_r;
    logic [bellek_paket::KELIME_ADR_GEN+1:2] tampon_adr_r;
    logic [bellek_paket::KELIME_GEN-1:0]     tampon_veri_r;
    logic [3:0]                              tampon_maske_r;

    logic zmn_adr;
    logic yazma;
    logic okuma;
    logic yukle;

    // ########################################
    // Decode
    // ########################################

    assign zmn_adr = bib_adr_i[bellek_paket::ZMN_BIT];
    assign yazma   = bib_sec_i && (bib_maske_i != 4'b0000) && !zmn_adr;
    assign okuma   = bib_sec_i && (bib_maske_i == 4'b0000) && !zmn_adr;

    // Write is posted only into an empty buffer
    assign yukle = yazma && !tampon_dolu_r;

    assign zmn_sec_o = bib_sec_i && (bib_maske_i == 4'b0000) && zmn_adr;
    assign zmn_ust_o = bib_adr_i[2];

    // ########################################
    // Posted write buffer
    // ########################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tampon_dolu_r <= 1'b0;
        end else if (yukle) begin
            tampon_dolu_r <= 1'b1;
        end else if (tampon_dolu_r && iomem_ready_i) begin
            tampon_dolu_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (yukle) begin
            tampon_adr_r   <= bib_adr_i[bellek_paket::KELIME_ADR_GEN+1:2];
            tampon_veri_r  <= bib_veri_i;
            tampon_maske_r <= bib_maske_i;
        end
    end

    // ########################################
    // Memory request
    // ########################################

    // Buffered write goes out first, so a later read sees it
    assign iomem_valid_o = tampon_dolu_r || okuma;
    assign iomem_addr_o  = tampon_dolu_r ? tampon_adr_r :
                                           bib_adr_i[bellek_paket::KELIME_ADR_GEN+1:2];
    assign iomem_wstrb_o = tampon_dolu_r ? tampon_maske_r : 4'b0000;
    assign iomem_wdata_o = tampon_veri_r;

    // ########################################
    // Core response
    // ########################################

    assign bib_veri_o = zmn_sec_o ? zmn_veri_i : iomem_rdata_i;

    // Ready while the buffer is full belongs to the write, not the read
    assign bib_durdur_o = (yazma && tampon_dolu_r) ||
                          (okuma && (tampon_dolu_r || !iomem_ready_i));

    // ########################################
    // Checks
    // ########################################

    // Pending write not overwritten before memory takes it
    a_tampon_korunur: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        tampon_dolu_r && !iomem_ready_i |=>
            tampon_dolu_r && $stable(tampon_adr_r) && $stable(tampon_veri_r) &&
            $stable(tampon_maske_r)
    );

    // Memory answers only a pending request
    a_hazir_istekle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        iomem_ready_i |-> iomem_valid_o
    );

endmodule

// ==== sim.f ====
hw/bellek_paket.sv
hw/buyruk_onbellegi.sv
hw/veri_yolu_denetleyici.sv
hw/anabellek_denetleyici.sv
hw/bellek_alt_sistemi.sv
testbench/bellek_modeli.sv
testbench/tb_bellek_alt_sistemi.sv

// ==== testbench/bellek_modeli.sv ====
// Word memory over byte address bits 18:2; ready is one pulse, 1 to 6 cycles after valid
`timescale 1ns/10ps

module bellek_modeli (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        iomem_valid_i,
    output logic        iomem_ready_o,
    input  logic [3:0]  iomem_wstrb_i,
    input  logic [31:0] iomem_addr_i,
    input  logic [31:0] iomem_wdata_i,
    output logic [31:0] iomem_rdata_o
);

    localparam int DERINLIK = 2 ** bellek_paket::KELIME_ADR_GEN;

    logic [31:0]                             bellek [DERINLIK];
    logic                                    mesgul_r;
    logic [2:0]                              gecikme_r;
    logic [bellek_paket::KELIME_ADR_GEN-1:0] kelime_adr;
    integer                                  tohum;

    function automatic logic [31:0] maskeli(input logic [31:0] eski, input logic [31:0] yeni,
                                            input logic [3:0] maske);
        logic [31:0] sonuc;
        sonuc = eski;
        for (int b = 0; b < 4; b++) begin
            if (maske[b]) begin
                sonuc[8*b +: 8] = yeni[8*b +: 8];
            end
        end
        return sonuc;
    endfunction

    assign kelime_adr = iomem_addr_i[bellek_paket::KELIME_ADR_GEN+1:2];

    initial begin
        tohum         = 32'h9ea105d8;
        iomem_ready_o = 1'b0;
        iomem_rdata_o = '0;
        // Fill pattern mixes every bit of the word address
        for (int i = 0; i < DERINLIK; i++) begin
            bellek[i] = 32'h1357_9bdf ^ (i * 32'd2654435761);
        end
    end

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            mesgul_r      <= 1'b0;
            gecikme_r     <= '0;
            iomem_ready_o <= 1'b0;
        end else if (iomem_ready_o) begin
            iomem_ready_o <= 1'b0;
            mesgul_r      <= 1'b0;
        end else if (mesgul_r) begin
            if (gecikme_r == 3'd0) begin
                iomem_ready_o      <= 1'b1;
                iomem_rdata_o      <= bellek[kelime_adr];
                bellek[kelime_adr] <= maskeli(bellek[kelime_adr], iomem_wdata_i, iomem_wstrb_i);
            end else begin
                gecikme_r <= gecikme_r - 3'd1;
            end
        end else if (iomem_valid_i) begin
            mesgul_r  <= 1'b1;
            gecikme_r <= 3'($unsigned($random(tohum)) % 6);
        end
    end

endmodule

// ==== testbench/tb_bellek_alt_sistemi.sv ====
// Fetches stay below word 'h100 and data traffic at 'h10000 and up, the cache does not snoop
`timescale 1ns/10ps

module tb_bellek_alt_sistemi;

    localparam int          BEKLEME_SINIRI = 200;
    localparam logic [16:0] VERI_TABAN     = 17'h10000;

    logic        clk_i;
    logic        rst_n_i;
    logic        l1b_istek_i;
    logic [bellek_paket::KELIME_ADR_GEN+1:2] l1b_adres_i;
    logic [31:0] l1b_deger_o;
    logic        l1b_bekle_o;
    logic        bib_sec_i;
    logic [31:0] bib_adr_i;
    logic [31:0] bib_veri_i;
    logic [3:0]  bib_maske_i;
    logic [31:0] bib_veri_o;
    logic        bib_durdur_o;
    logic        iomem_valid_o;
    logic        iomem_ready_i;
    logic [3:0]  iomem_wstrb_o;
    logic [31:0] iomem_addr_o;
    logic [31:0] iomem_wdata_o;
    logic [31:0] iomem_rdata_i;

    logic [31:0] golge [int];
    logic [31:0] dis_adresler [$];
    // Accepted writes as byte address, strobes and data
    logic [67:0] bekleyen_yazmalar [$];
    logic [67:0] siradaki_yazma;
    logic [63:0] dongu_sayisi;
    logic        onceki_valid = 1'b0;
    integer      tohum;

    bellek_alt_sistemi i_dut (.*);

    bellek_modeli i_bellek (
        .clk_i         (clk_i        ),
        .rst_n_i       (rst_n_i      ),
        .iomem_valid_i (iomem_valid_o),
        .iomem_ready_o (iomem_ready_i),
        .iomem_wstrb_i (iomem_wstrb_o),
        .iomem_addr_i  (iomem_addr_o ),
        .iomem_wdata_i (iomem_wdata_o),
        .iomem_rdata_o (iomem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Cycle timer mirror
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            dongu_sayisi <= '0;
        end else begin
            dongu_sayisi <= dongu_sayisi + 64'd1;
        end
    end

    // Address of every external transaction in order, and each write drained from the buffer
    always @(negedge clk_i) begin
        if (iomem_valid_o === 1'b1 && onceki_valid !== 1'b1) begin
            dis_adresler.push_back(iomem_addr_o);
            if (iomem_wstrb_o !== 4'b0000) begin
                if (bekleyen_yazmalar.size() == 0) begin
                    $display("External write at %0t ns to %h with no write posted", $time,
                             iomem_addr_o);
                    $display("TB FAILED");
                    $fatal(1, "unexpected write");
                end else begin
                    siradaki_yazma = bekleyen_yazmalar.pop_front();
                    karsilastir("iomem_addr_o", iomem_addr_o, siradaki_yazma[67:36]);
                    karsilastir("iomem_wstrb_o", 32'(iomem_wstrb_o),
                                32'(siradaki_yazma[35:32]));
                    karsilastir("iomem_wdata_o", iomem_wdata_o, siradaki_yazma[31:0]);
                end
            end
        end
        onceki_valid = iomem_valid_o;
    end

    function automatic logic [31:0] bayt_adr(input logic [16:0] adr);
        return {13'd0, adr, 2'b00};
    endfunction

    function automatic logic [31:0] beklenen_kelime(input logic [16:0] adr,
                                                    input logic [31:0] yeni,
                                                    input logic [3:0] maske);
        logic [31:0] kelime;
        kelime = golge.exists(int'(adr)) ? golge[int'(adr)] :
                 32'h1357_9bdf ^ ({15'd0, adr} * 32'd2654435761);
        for (int b = 0; b < 4; b++) begin
            if (maske[b]) begin
                kelime[8*b +: 8] = yeni[8*b +: 8];
            end
        end
        return kelime;
    endfunction

    task automatic karsilastir(input string ad, input logic [31:0] gercek,
                               input logic [31:0] beklenen);
        if (gercek !== beklenen) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, ad, gercek, beklenen);
            $display("TB FAILED");
            $fatal(1, "value check");
        end
    endtask

    task automatic zaman_asimi(input string port);
        $display("Timeout at %0t ns: %s still stalled after %0d cycles", $time, port,
                 BEKLEME_SINIRI);
        $display("TB FAILED");
        $fatal(1, "stalled port");
    endtask

    // ########################################
    // Port operations
    // ########################################

    task automatic getir(input logic [16:0] adr, output int bekleme);
        logic [31:0] beklenen;
        beklenen    = beklenen_kelime(adr, '0, 4'b0000);
        l1b_istek_i = 1'b1;
        l1b_adres_i = adr;
        bekleme     = 0;
        @(negedge clk_i);
        while (l1b_bekle_o) begin
            bekleme++;
            if (bekleme > BEKLEME_SINIRI) begin
                zaman_asimi("instruction port (l1b_bekle_o)");
            end
            @(negedge clk_i);
        end
        karsilastir("l1b_deger_o", l1b_deger_o, beklenen);
        @(posedge clk_i);
        #10;
        l1b_istek_i = 1'b0;
    endtask

    task automatic durdur_bekle();
        int sure;
        sure = 0;
        @(negedge clk_i);
        while (bib_durdur_o) begin
            sure++;
            if (sure > BEKLEME_SINIRI) begin
                zaman_asimi("data port (bib_durdur_o)");
            end
            @(negedge clk_i);
        end
    endtask

    task automatic yaz(input logic [16:0] adr, input logic [31:0] veri, input logic [3:0] maske);
        bib_sec_i   = 1'b1;
        bib_adr_i   = bayt_adr(adr);
        bib_veri_i  = veri;
        bib_maske_i = maske;
        durdur_bekle();
        golge[int'(adr)] = beklenen_kelime(adr, veri, maske);
        bekleyen_yazmalar.push_back({bayt_adr(adr), maske, veri});
        @(posedge clk_i);
        #10;
        bib_sec_i   = 1'b0;
        bib_maske_i = 4'b0000;
    endtask

    task automatic oku(input logic [16:0] adr);
        logic [31:0] beklenen;
        beklenen    = beklenen_kelime(adr, '0, 4'b0000);
        bib_sec_i   = 1'b1;
        bib_adr_i   = bayt_adr(adr);
        bib_maske_i = 4'b0000;
        durdur_bekle();
        karsilastir("bib_veri_o", bib_veri_o, beklenen);
        @(posedge clk_i);
        #10;
        bib_sec_i = 1'b0;
    endtask

    // Leaves bib_sec_i high, returns at the falling edge
    task automatic zaman_oku(input logic ust, output logic [31:0] deger);
        bib_sec_i   = 1'b1;
        bib_maske_i = 4'b0000;
        bib_adr_i   = (32'd1 << bellek_paket::ZMN_BIT) | (ust ? 32'd4 : 32'd0);
        @(negedge clk_i);
        karsilastir("bib_durdur_o", 32'(bib_durdur_o), 32'd0);
        deger = bib_veri_o;
        karsilastir("bib_veri_o", deger, ust ? dongu_sayisi[63:32] : dongu_sayisi[31:0]);
    endtask

    // ########################################
    // Test sequence
    // ########################################

    initial begin
        int          n;
        int          bekleme;
        int          secim;
        logic [31:0] ilk;
        logic [31:0] son;
        tohum       = 32'h9ea105d8;
        rst_n_i     = 1'b0;
        l1b_istek_i = 1'b0;
        l1b_adres_i = '0;
        bib_sec_i   = 1'b0;
        bib_adr_i   = '0;
        bib_veri_i  = '0;
        bib_maske_i = 4'b0000;
        repeat (5) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        karsilastir("iomem_valid_o", 32'(iomem_valid_o), 32'd0);
        @(posedge clk_i);
        #10;

        // Miss, hit, then a conflicting tag on the same line
        getir(17'h0005, bekleme);
        n = dis_adresler.size();
        getir(17'h0005, bekleme);
        karsilastir("l1b_bekle_o cycles", bekleme, 0);
        karsilastir("iomem_valid_o rises", dis_adresler.size(), n);
        getir(17'h0005 ^ 17'(bellek_paket::SATIR_SAYISI), bekleme);
        karsilastir("iomem_valid_o rises", dis_adresler.size(), n + 1);

        // Second write and the read both stall behind the buffer
        yaz(VERI_TABAN + 17'd3, 32'h1122_3344, 4'b0001);
        yaz(VERI_TABAN + 17'd3, 32'haabb_ccdd, 4'b0110);
        oku(VERI_TABAN + 17'd3);
        yaz(VERI_TABAN + 17'd3, 32'hdead_beef, 4'b1000);
        oku(VERI_TABAN + 17'd3);

        n = dis_adresler.size();
        fork
            getir(17'h0042, bekleme);
            oku(VERI_TABAN + 17'd9);
        join
        karsilastir("first iomem_addr_o", dis_adresler[n], bayt_adr(VERI_TABAN + 17'd9));

        zaman_oku(1'b0, ilk);
        repeat (7) @(posedge clk_i);
        #10;
        zaman_oku(1'b0, son);
        karsilastir("timer low word delta", son - ilk, 32'd7);
        @(posedge clk_i);
        #10;
        zaman_oku(1'b1, son);
        karsilastir("timer high word", son, 32'd0);
        @(posedge clk_i);
        #10;
        bib_sec_i = 1'b0;

        for (int i = 0; i < 200; i++) begin
            secim = $unsigned($random(tohum)) % 5;
            case (secim)
                0: getir(17'($unsigned($random(tohum)) % (4 * bellek_paket::SATIR_SAYISI)),
                         bekleme);
                1: yaz(VERI_TABAN | 17'($random(tohum) & 15), $random(tohum),
                       4'($unsigned($random(tohum)) % 15 + 1));
                2: oku(VERI_TABAN | 17'($random(tohum) & 15));
                3: begin
                    zaman_oku(1'($random(tohum)), son);
                    @(posedge clk_i);
                    #10;
                    bib_sec_i = 1'b0;
                end
                default: fork
                    getir(17'($unsigned($random(tohum)) % (4 * bellek_paket::SATIR_SAYISI)),
                          bekleme);
                    oku(VERI_TABAN | 17'($random(tohum) & 15));
                join
            endcase
        end

        $display("TB PASSED");
        $finish;
    end

endmodule
